//--- rtl/bitcnt_pkg.sv
// Shared definitions for the pipelined bit-scan unit
// Operand width, opcode encoding, stage structs and the index-width helper
package bitcnt_pkg;

  // Operand width of the whole unit
  localparam int unsigned DATA_W = 32;

  // Smallest index width for num_idx positions, never below one bit
  function automatic int unsigned idx_width(input int unsigned num_idx);
    return (num_idx > 32'd1) ? unsigned'($clog2(num_idx)) : 32'd1;
  endfunction

  // A count field must hold 0 up to DATA_W inclusive
  localparam int unsigned CNT_W = idx_width(DATA_W + 1);

  // Operation codes, values 4 to 7 are illegal
  typedef enum logic [2:0] {
    OP_CLZ  = 3'd0,
    OP_CTZ  = 3'd1,
    OP_CPOP = 3'd2,
    OP_NORM = 3'd3
  } bitcnt_op_e;

  // Result selector produced by decode
  typedef enum logic [1:0] {
    SEL_LEAD  = 2'd0,
    SEL_TRAIL = 2'd1,
    SEL_POP   = 2'd2,
    SEL_NORM  = 2'd3
  } bitcnt_sel_e;

  // Request as presented at the unit input
  typedef struct packed {
    bitcnt_op_e        op;
    logic [DATA_W-1:0] operand;
  } bitcnt_req_t;

  // Decoded request handed from decode to execute
  typedef struct packed {
    bitcnt_sel_e       sel;
    logic              illegal;
    logic [DATA_W-1:0] operand;
  } bitcnt_ctrl_t;

  // Result of one request
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [CNT_W-1:0]  cnt;
    logic              empty;
    logic              illegal;
  } bitcnt_res_t;

endpackage

//--- rtl/lzc.sv
// Leading or trailing zero counter built as a binary selection tree
// Reports the position of the first set bit and flags an all-zero input
`timescale 1ns/10ps

module lzc import bitcnt_pkg::*; #(
  parameter int unsigned WIDTH = 32,
  // 1 searches from the MSB, 0 searches from the LSB
  parameter bit          MODE  = 1'b1
) (
  input  logic [WIDTH-1:0]            in_i,
  output logic [idx_width(WIDTH)-1:0] cnt_o,
  output logic                        empty_o
);

  if (WIDTH == 1) begin : gen_single

    // A single bit has only position zero, which is also WIDTH minus one
    assign cnt_o   = 1'b0;
    assign empty_o = ~in_i[0];

  end else begin : gen_tree

    // Number of tree levels and leaves, leaves padded up to a power of two
    localparam int unsigned NUM_LEVELS = $clog2(WIDTH);
    localparam int unsigned NUM_LEAVES = 2 ** NUM_LEVELS;
    localparam int unsigned NUM_NODES  = 2 * NUM_LEAVES - 1;

    // Input in search order, bit 0 is the first bit looked at
    logic [WIDTH-1:0] in_ord;

    // Heap-ordered tree: node n has children 2n+1 and 2n+2
    // The leaves sit at NUM_LEAVES-1 up to NUM_NODES-1
    logic [NUM_NODES-1:0]                 node_sel;
    logic [NUM_NODES-1:0][NUM_LEVELS-1:0] node_idx;

    // For a leading count the input is mirrored so that the MSB comes first
    always_comb begin
      for (int unsigned i = 0; i < WIDTH; i++) begin
        in_ord[i] = MODE ? in_i[WIDTH-1-i] : in_i[i];
      end
    end

    for (genvar k = 0; k < NUM_LEAVES; k++) begin : g_leaf
      // Padding leaves never win and carry WIDTH-1, so an empty input
      // always ends on that index
      localparam int unsigned LEAF_IDX = (k < WIDTH) ? k : WIDTH - 1;

      if (k < WIDTH) begin : g_real
        assign node_sel[NUM_LEAVES-1+k] = in_ord[k];
      end else begin : g_pad
        assign node_sel[NUM_LEAVES-1+k] = 1'b0;
      end
      assign node_idx[NUM_LEAVES-1+k] = NUM_LEVELS'(LEAF_IDX);
    end

    for (genvar n = 0; n < NUM_LEAVES - 1; n++) begin : g_node
      // The left child covers the lower positions and so has priority
      assign node_sel[n] = node_sel[2*n+1] | node_sel[2*n+2];
      assign node_idx[n] = node_sel[2*n+1] ? node_idx[2*n+1] : node_idx[2*n+2];
    end

    // Root of the tree holds the winning index
    assign cnt_o   = node_idx[0];
    assign empty_o = ~node_sel[0];

  end

endmodule

//--- rtl/popcount.sv
// Population counter built as a balanced adder tree
// Partial sums grow by one bit on every level towards the root
`timescale 1ns/10ps

module popcount import bitcnt_pkg::*; #(
  parameter int unsigned WIDTH = 32
) (
  input  logic [WIDTH-1:0]              in_i,
  output logic [idx_width(WIDTH+1)-1:0] cnt_o
);

  // Tree shape, leaves padded with zeros up to a power of two
  localparam int unsigned NUM_LEVELS = $clog2(WIDTH);
  localparam int unsigned NUM_LEAVES = 2 ** NUM_LEVELS;
  localparam int unsigned OUT_W      = idx_width(WIDTH + 1);

  logic [NUM_LEAVES-1:0] leaves;

  // Zero padding does not change the sum
  always_comb begin
    leaves              = '0;
    leaves[WIDTH-1:0]   = in_i;
  end

  for (genvar lvl = 0; lvl <= NUM_LEVELS; lvl++) begin : g_lvl
    // Level lvl has NUM_LEAVES >> lvl sums of lvl+1 bits each
    localparam int unsigned NODES = NUM_LEAVES >> lvl;

    logic [NODES-1:0][lvl:0] sum;

    if (lvl == 0) begin : g_leaf
      assign sum = leaves;
    end else begin : g_add
      for (genvar k = 0; k < NODES; k++) begin : g_pair
        // Both operands are widened first so the carry is kept
        assign sum[k] = {1'b0, g_lvl[lvl-1].sum[2*k]} +
                        {1'b0, g_lvl[lvl-1].sum[2*k+1]};
      end
    end
  end

  // The root may be wider than needed when WIDTH is not a power of two
  assign cnt_o = g_lvl[NUM_LEVELS].sum[0][OUT_W-1:0];

endmodule

//--- rtl/bitcnt_decode.sv
// Decode stage of the bit-scan unit
// Registers a request and turns its opcode into a result selector
`timescale 1ns/10ps

module bitcnt_decode import bitcnt_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         req_valid_i,
  input  bitcnt_req_t  req_i,
  output logic         ctrl_valid_o,
  output bitcnt_ctrl_t ctrl_o
);

  bitcnt_ctrl_t ctrl_d;

  // Opcode to selector mapping
  always_comb begin
    ctrl_d.operand = req_i.operand;
    ctrl_d.sel     = SEL_LEAD;
    ctrl_d.illegal = 1'b0;
    case (req_i.op)
      OP_CLZ:  ctrl_d.sel = SEL_LEAD;
      OP_CTZ:  ctrl_d.sel = SEL_TRAIL;
      OP_CPOP: ctrl_d.sel = SEL_POP;
      OP_NORM: ctrl_d.sel = SEL_NORM;
      // Codes 4 to 7 are flagged and later zeroed in execute
      default: ctrl_d.illegal = 1'b1;
    endcase
  end

  // The valid bit follows the strobe on every edge
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ctrl_valid_o <= 1'b0;
    end else begin
      ctrl_valid_o <= req_valid_i;
    end
  end

  // Payload is only loaded for a real request and holds otherwise
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      ctrl_o <= ctrl_d;
    end
  end

endmodule

//--- rtl/bitcnt_execute.sv
// Execute stage of the bit-scan unit
// Runs both zero counters, the popcount and the normalize shift, then selects
`timescale 1ns/10ps

module bitcnt_execute import bitcnt_pkg::*; (
  input  bitcnt_ctrl_t ctrl_i,
  output bitcnt_res_t  res_o
);

  localparam int unsigned IDX_W = idx_width(DATA_W);

  // Raw counter outputs, which read WIDTH-1 on an empty operand
  logic [IDX_W-1:0] lead_raw;
  logic [IDX_W-1:0] trail_raw;
  logic             lead_empty;
  logic             trail_empty;
  logic [CNT_W-1:0] pop_cnt;

  // Corrected counts in the range 0 to DATA_W
  logic [CNT_W-1:0]  lead_cnt;
  logic [CNT_W-1:0]  trail_cnt;
  logic [DATA_W-1:0] norm_data;

  lzc #(
    .WIDTH (DATA_W),
    .MODE  (1'b1)
  ) i_lead (
    .in_i    (ctrl_i.operand),
    .cnt_o   (lead_raw),
    .empty_o (lead_empty)
  );

  lzc #(
    .WIDTH (DATA_W),
    .MODE  (1'b0)
  ) i_trail (
    .in_i    (ctrl_i.operand),
    .cnt_o   (trail_raw),
    .empty_o (trail_empty)
  );

  popcount #(
    .WIDTH (DATA_W)
  ) i_pop (
    .in_i  (ctrl_i.operand),
    .cnt_o (pop_cnt)
  );

  // An empty operand has DATA_W zeros, not WIDTH-1
  assign lead_cnt  = lead_empty ? CNT_W'(DATA_W) : CNT_W'(lead_raw);
  assign trail_cnt = trail_empty ? CNT_W'(DATA_W) : CNT_W'(trail_raw);

  // The raw count suffices for the shift since a zero operand shifts to zero anyway
  assign norm_data = ctrl_i.operand << lead_raw;

  always_comb begin
    res_o         = '0;
    res_o.empty   = lead_empty;
    res_o.illegal = ctrl_i.illegal;
    case (ctrl_i.sel)
      SEL_LEAD: begin
        res_o.cnt  = lead_cnt;
        res_o.data = DATA_W'(lead_cnt);
      end
      SEL_TRAIL: begin
        res_o.cnt  = trail_cnt;
        res_o.data = DATA_W'(trail_cnt);
      end
      SEL_POP: begin
        res_o.cnt  = pop_cnt;
        res_o.data = DATA_W'(pop_cnt);
      end
      default: begin
        // Normalize reports the shift amount beside the shifted operand
        res_o.cnt  = lead_cnt;
        res_o.data = norm_data;
      end
    endcase
    // Illegal requests only carry their flag
    if (ctrl_i.illegal) begin
      res_o.data  = '0;
      res_o.cnt   = '0;
      res_o.empty = 1'b0;
    end
  end

endmodule

//--- rtl/bitcnt_result.sv
// Result stage of the bit-scan unit
// Registers the execute outcome and marks it with a one-cycle pulse
`timescale 1ns/10ps

module bitcnt_result import bitcnt_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        valid_i,
  input  bitcnt_res_t res_i,
  output logic        res_valid_o,
  output bitcnt_res_t res_o
);

  // Output pulse, one cycle per accepted request
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      res_valid_o <= 1'b0;
    end else begin
      res_valid_o <= valid_i;
    end
  end

  // The last result stays on the outputs between pulses
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      res_o <= res_i;
    end
  end

endmodule

//--- rtl/bitcnt_top.sv
// Top level of the pipelined bit-scan unit
// Decode, combinational execute and result register give a fixed latency of two
`timescale 1ns/10ps

module bitcnt_top import bitcnt_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        req_valid_i,
  input  bitcnt_req_t req_i,
  output logic        res_valid_o,
  output bitcnt_res_t res_o
);

  // Decode to execute
  bitcnt_ctrl_t ctrl;
  logic         ctrl_valid;

  // Execute to result
  bitcnt_res_t  exe_res;

  bitcnt_decode i_decode (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .ctrl_valid_o (ctrl_valid),
    .ctrl_o       (ctrl)
  );

  bitcnt_execute i_execute (
    .ctrl_i (ctrl),
    .res_o  (exe_res)
  );

  // The valid bit bypasses execute since that stage has no state
  bitcnt_result i_result (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .valid_i     (ctrl_valid),
    .res_i       (exe_res),
    .res_valid_o (res_valid_o),
    .res_o       (res_o)
  );

endmodule

//--- verification/bitcnt_props.sv
// Concurrent checks on the bit-scan unit
// Covers the valid timing after reset, the fixed latency and illegal results
`timescale 1ns/10ps

module bitcnt_props import bitcnt_pkg::*; (
  input logic        clk_i,
  input logic        rst_n_i,
  input logic        req_valid_i,
  input logic        res_valid_i,
  input bitcnt_res_t res_i
);

  // Both valid registers were cleared by reset, so the first cycle after release is quiet
  a_quiet_after_reset: assert property (
    @(posedge clk_i) $rose(rst_n_i) |=> !res_valid_i
  ) else $error("result valid high right after reset release");

  // Every strobe leaves the unit exactly two edges later, gaps included
  // Both pipeline registers must have been out of reset for the past values to count
  a_fixed_latency: assert property (
    @(posedge clk_i) rst_n_i && $past(rst_n_i) && $past(rst_n_i, 2)
      |-> res_valid_i == $past(req_valid_i, 2)
  ) else $error("result valid does not follow the request strobe by two cycles");

  // An illegal opcode carries only its flag
  a_illegal_zero: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
      res_valid_i && res_i.illegal |-> res_i.data == '0 && res_i.cnt == '0
  ) else $error("illegal result with nonzero data or count");

endmodule

bind bitcnt_top bitcnt_props i_props (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .req_valid_i (req_valid_i),
  .res_valid_i (res_valid_o),
  .res_i       (res_o)
);

//--- verification/bitcnt_tb.sv
// Testbench for the pipelined bit-scan unit
// Directed and random requests checked against a loop-based reference model
`timescale 1ns/10ps

module bitcnt_tb import bitcnt_pkg::*; ();

  // Request counts of the test groups
  localparam int unsigned WALK_REQ  = 2 * (DATA_W + 2);
  localparam int unsigned RAND_CNT  = 20;
  localparam int unsigned POP_REQ   = 2 + RAND_CNT;
  localparam int unsigned NORM_REQ  = 5 + RAND_CNT;
  localparam int unsigned ILL_REQ   = 8;
  localparam int unsigned B2B_REQ   = 60;
  localparam int unsigned GAP_REQ   = 30;
  localparam int unsigned NUM_REQ   = WALK_REQ + POP_REQ + NORM_REQ + ILL_REQ + B2B_REQ + GAP_REQ;
  localparam int unsigned RESET_CYC = 16;
  localparam int unsigned DRAIN_CYC = 8;
  localparam int unsigned LATENCY   = 2;
  // Gaps stay short, so half the request count again covers them
  localparam int unsigned CYCLE_LIMIT = NUM_REQ * 3 / 2 + RESET_CYC + DRAIN_CYC;

  // A request in flight with its expected result and the cycle it was driven in
  typedef struct packed {
    bitcnt_res_t res;
    logic [31:0] cycle;
  } pending_t;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        req_valid;
  bitcnt_req_t req;
  logic        res_valid;
  bitcnt_res_t res;

  pending_t    pending_q[$];
  int unsigned cycle_cnt   = 0;
  int unsigned req_cnt     = 0;
  int unsigned checked_cnt = 0;
  integer      seed        = 32'h85b0;

  bitcnt_top UUT (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .req_valid_i (req_valid),
    .req_i       (req),
    .res_valid_o (res_valid),
    .res_o       (res)
  );

  always #50 clk = ~clk;

  // Expected result from the opcode rules, counted bit by bit
  function automatic bitcnt_res_t ref_bitcnt(input bitcnt_req_t r);
    bitcnt_res_t exp;
    int unsigned lead;
    int unsigned trail;
    int unsigned ones;
    bit          seen;
    exp  = '0;
    lead = 0;
    seen = 1'b0;
    for (int i = DATA_W - 1; i >= 0; i--) begin
      if (r.operand[i]) seen = 1'b1;
      else if (!seen) lead++;
    end
    trail = 0;
    seen  = 1'b0;
    ones  = 0;
    for (int i = 0; i < DATA_W; i++) begin
      if (r.operand[i]) begin
        seen = 1'b1;
        ones++;
      end else if (!seen) begin
        trail++;
      end
    end
    exp.empty = (r.operand == '0);
    case (r.op)
      OP_CLZ:  exp.cnt = CNT_W'(lead);
      OP_CTZ:  exp.cnt = CNT_W'(trail);
      OP_CPOP: exp.cnt = CNT_W'(ones);
      OP_NORM: exp.cnt = CNT_W'(lead);
      default: begin
        exp         = '0;
        exp.illegal = 1'b1;
      end
    endcase
    // A shift by the full width leaves zero, which is the rule for a zero operand
    if (r.op == OP_NORM) exp.data = r.operand << lead;
    else exp.data = DATA_W'(exp.cnt);
    return exp;
  endfunction

  // Operand with a random amount of leading or trailing zeros
  function automatic logic [DATA_W-1:0] rand_operand();
    logic [DATA_W-1:0] value;
    logic [5:0]        sh;
    value = $random(seed);
    sh    = $random(seed);
    return sh[5] ? value >> sh[4:0] : value << sh[4:0];
  endfunction

  task automatic stop_run(input string why);
    $display("%s at time %0t", why, $time);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_value_error(input string name, input logic [DATA_W-1:0] got,
                                    input logic [DATA_W-1:0] exp);
    $display("Fail at time %0t: %s is %h, expected %h", $time, name, got, exp);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // Each field on its own so the message names the one that is wrong
  task automatic check_res(input bitcnt_res_t got, input bitcnt_res_t exp);
    if (got.data !== exp.data) report_value_error("res_o.data", got.data, exp.data);
    if (got.cnt !== exp.cnt) report_value_error("res_o.cnt", got.cnt, exp.cnt);
    if (got.empty !== exp.empty) report_value_error("res_o.empty", got.empty, exp.empty);
    if (got.illegal !== exp.illegal) begin
      report_value_error("res_o.illegal", got.illegal, exp.illegal);
    end
  endtask

  task automatic check_latency(input int unsigned got, input int unsigned exp);
    if (got != exp) report_value_error("res_valid_o latency", got, exp);
  endtask

  // One request on the next falling edge, its expected result is queued
  task automatic drive_req(input logic [2:0] code, input logic [DATA_W-1:0] operand);
    pending_t entry;
    @(negedge clk);
    req_valid   = 1'b1;
    req.op      = bitcnt_op_e'(code);
    req.operand = operand;
    entry.res   = ref_bitcnt(req);
    entry.cycle = cycle_cnt;
    pending_q.push_back(entry);
    req_cnt++;
  endtask

  task automatic drive_idle(input int unsigned cycles);
    repeat (cycles) begin
      @(negedge clk);
      req_valid = 1'b0;
    end
  endtask

  // Cycle count and run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) stop_run("Timeout, the run took too many cycles");
  end

  // Outputs are read on the falling edge, half a cycle after they change
  always @(negedge clk) begin : compare_proc
    pending_t head;
    if (rst_n) begin
      if (res_valid) begin
        if (pending_q.size() == 0) begin
          stop_run("Result pulse without a pending request");
        end else begin
          head = pending_q.pop_front();
          check_latency(cycle_cnt - head.cycle, LATENCY);
          check_res(res, head.res);
          checked_cnt++;
        end
      end else if (pending_q.size() != 0 && cycle_cnt - pending_q[0].cycle >= LATENCY) begin
        stop_run("Result pulse missing for a pending request");
      end
    end
  end

  initial begin : stimulus
    logic [31:0] rnd;
    int unsigned gap;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    repeat (RESET_CYC) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Walking single ones, all ones and zero through both zero counters
    for (int i = 0; i < DATA_W; i++) begin
      drive_req(OP_CLZ, DATA_W'(1) << i);
      drive_req(OP_CTZ, DATA_W'(1) << i);
    end
    drive_req(OP_CLZ, '1);
    drive_req(OP_CTZ, '1);
    drive_req(OP_CLZ, '0);
    drive_req(OP_CTZ, '0);

    // Population count
    drive_req(OP_CPOP, '0);
    drive_req(OP_CPOP, '1);
    for (int i = 0; i < RAND_CNT; i++) drive_req(OP_CPOP, rand_operand());

    // Normalize on edge and random operands
    drive_req(OP_NORM, '0);
    drive_req(OP_NORM, 32'h0000_0001);
    drive_req(OP_NORM, 32'h8000_0000);
    drive_req(OP_NORM, '1);
    drive_req(OP_NORM, 32'h0001_0000);
    for (int i = 0; i < RAND_CNT; i++) drive_req(OP_NORM, rand_operand());

    // Opcodes 4 to 7 with random and zero operands
    for (int i = 4; i < 8; i++) begin
      drive_req(3'(i), rand_operand());
      drive_req(3'(i), '0);
    end

    // Back to back with mixed opcodes, about one in eight illegal
    for (int i = 0; i < B2B_REQ; i++) begin
      rnd = $random(seed);
      drive_req({rnd[5:3] == 3'd0, rnd[1:0]}, rand_operand());
    end

    // Short random gaps in the strobe
    for (int i = 0; i < GAP_REQ; i++) begin
      gap = $random(seed);
      drive_idle(gap % 3);
      rnd = $random(seed);
      drive_req({1'b0, rnd[1:0]}, rand_operand());
    end

    drive_idle(DRAIN_CYC);
    if (pending_q.size() != 0 || checked_cnt != req_cnt) begin
      stop_run("Results still missing after the pipeline drained");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

//--- compile.f
rtl/bitcnt_pkg.sv
rtl/lzc.sv
rtl/popcount.sv
rtl/bitcnt_decode.sv
rtl/bitcnt_execute.sv
rtl/bitcnt_result.sv
rtl/bitcnt_top.sv
verification/bitcnt_props.sv
verification/bitcnt_tb.sv

//--- Bender.yml
package:
  name: bitcnt

sources:
  # Shared package comes first
  - files:
      - rtl/bitcnt_pkg.sv
  # Design sources in dependency order
  - files:
      - rtl/lzc.sv
      - rtl/popcount.sv
      - rtl/bitcnt_decode.sv
      - rtl/bitcnt_execute.sv
      - rtl/bitcnt_result.sv
      - rtl/bitcnt_top.sv
  # Verification sources
  - target: test
    files:
      - verification/bitcnt_props.sv
      - verification/bitcnt_tb.sv
